// File: design/core_pkg.sv
`default_nettype none

package core_pkg;

  // datapath and register file sizes
  localparam int xlen = 32;
  localparam int reg_addr_width = 4;
  localparam int reg_count = 16;

  typedef logic [xlen-1:0] data_t;
  typedef logic [reg_addr_width-1:0] reg_addr_t;

  // RISC-V major opcodes of the supported subset
  typedef enum logic [6:0] {
    op_lui = 7'b0110111,
    op_imm = 7'b0010011,
    op_reg = 7'b0110011
  } opcode_e;

  typedef enum logic [1:0] {
    alu_add = 2'd0,
    alu_sub = 2'd1,
    alu_xor = 2'd2,
    alu_and = 2'd3
  } alu_fn_e;

  // lui ignores rs1, every other op reads it
  function automatic logic reads_rs1(opcode_e op);
    return op != op_lui;
  endfunction

  // only register-register ops read rs2
  function automatic logic reads_rs2(opcode_e op);
    return op == op_reg;
  endfunction

endpackage

`default_nettype wire

// File: design/core_slice.sv
`timescale 1ns/1ps
`default_nettype none

module core_slice (
  input  logic                clock,
  input  logic                reset,
  input  logic                in_valid,
  input  core_pkg::opcode_e   in_op,
  input  core_pkg::alu_fn_e   in_fn,
  input  core_pkg::reg_addr_t in_rd,
  input  core_pkg::reg_addr_t in_rs1,
  input  core_pkg::reg_addr_t in_rs2,
  input  core_pkg::data_t     in_imm,
  output logic                busy,
  output logic                wb_valid,
  output core_pkg::reg_addr_t wb_rd,
  output core_pkg::data_t     wb_data
);

  core_pkg::reg_addr_t rs1_addr;
  core_pkg::reg_addr_t rs2_addr;
  core_pkg::data_t     rs1_data;
  core_pkg::data_t     rs2_data;
  logic                ex_valid;
  core_pkg::reg_addr_t ex_rd;

  // issue to execute link
  exec_if exec_link ();

  issue_stage issue0 (
    .clock    (clock),
    .reset    (reset),
    .in_valid (in_valid),
    .in_op    (in_op),
    .in_fn    (in_fn),
    .in_rd    (in_rd),
    .in_rs1   (in_rs1),
    .in_rs2   (in_rs2),
    .in_imm   (in_imm),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .ex_valid (ex_valid),
    .ex_rd    (ex_rd),
    .wb_valid (wb_valid),
    .wb_rd    (wb_rd),
    .busy     (busy),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .exec     (exec_link.issue)
  );

  execute_pipe execute0 (
    .clock    (clock),
    .reset    (reset),
    .exec     (exec_link.execute),
    .ex_valid (ex_valid),
    .ex_rd    (ex_rd),
    .wb_valid (wb_valid),
    .wb_rd    (wb_rd),
    .wb_data  (wb_data)
  );

  // writeback pulse is the write strobe
  register_file regfile0 (
    .clock        (clock),
    .reset        (reset),
    .rs1_addr     (rs1_addr),
    .rs2_addr     (rs2_addr),
    .write_enable (wb_valid),
    .write_addr   (wb_rd),
    .write_data   (wb_data),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data)
  );

endmodule

`default_nettype wire

// File: design/exec_if.sv
`timescale 1ns/1ps
`default_nettype none

interface exec_if;

  // valid is a one-cycle issue pulse and the execute side never stalls
  logic valid;
  core_pkg::opcode_e op;
  core_pkg::alu_fn_e fn;
  core_pkg::reg_addr_t rd;
  // operands already selected by the issue stage
  core_pkg::data_t operand_a;
  core_pkg::data_t operand_b;

  modport issue (
    output valid,
    output op,
    output fn,
    output rd,
    output operand_a,
    output operand_b
  );

  modport execute (
    input valid,
    input op,
    input fn,
    input rd,
    input operand_a,
    input operand_b
  );

endinterface

`default_nettype wire

// File: design/execute_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module execute_pipe (
  input  logic                clock,
  input  logic                reset,
  exec_if.execute             exec,
  output logic                ex_valid,
  output core_pkg::reg_addr_t ex_rd,
  output logic                wb_valid,
  output core_pkg::reg_addr_t wb_rd,
  output core_pkg::data_t     wb_data
);

  core_pkg::data_t alu_out;
  core_pkg::data_t result;

  // execute stage destination feeds the hazard check
  assign ex_valid = exec.valid;
  assign ex_rd    = exec.rd;

  // ALU where add and sub wrap at 32 bits
  always_comb begin
    case (exec.fn)
      core_pkg::alu_add: alu_out = exec.operand_a + exec.operand_b;
      core_pkg::alu_sub: alu_out = exec.operand_a - exec.operand_b;
      core_pkg::alu_xor: alu_out = exec.operand_a ^ exec.operand_b;
      core_pkg::alu_and: alu_out = exec.operand_a & exec.operand_b;
      default:           alu_out = '0;
    endcase
  end

  // lui passes the immediate through and ignores fn
  always_comb begin
    if (exec.op == core_pkg::op_lui) begin
      result = exec.operand_b;
    end else begin
      result = alu_out;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= exec.valid;
    end
  end

  // writeback register
  always_ff @(posedge clock) begin
    if (exec.valid) begin
      wb_rd   <= exec.rd;
      wb_data <= result;
    end
  end

  // only the supported opcodes reach the result select
  assert property (@(posedge clock) disable iff (reset)
    exec.valid |-> (exec.op inside {core_pkg::op_lui, core_pkg::op_imm, core_pkg::op_reg}));

endmodule

`default_nettype wire

// File: design/issue_stage.sv
`timescale 1ns/1ps
`default_nettype none

module issue_stage (
  input  logic                clock,
  input  logic                reset,
  input  logic                in_valid,
  input  core_pkg::opcode_e   in_op,
  input  core_pkg::alu_fn_e   in_fn,
  input  core_pkg::reg_addr_t in_rd,
  input  core_pkg::reg_addr_t in_rs1,
  input  core_pkg::reg_addr_t in_rs2,
  input  core_pkg::data_t     in_imm,
  input  core_pkg::data_t     rs1_data,
  input  core_pkg::data_t     rs2_data,
  input  logic                ex_valid,
  input  core_pkg::reg_addr_t ex_rd,
  input  logic                wb_valid,
  input  core_pkg::reg_addr_t wb_rd,
  output logic                busy,
  output core_pkg::reg_addr_t rs1_addr,
  output core_pkg::reg_addr_t rs2_addr,
  exec_if.issue               exec
);

  logic use_rs1;
  logic use_rs2;
  logic ex_conflict;
  logic wb_conflict;
  logic accept;
  core_pkg::data_t operand_a;
  core_pkg::data_t operand_b;

  // operands come straight from the register file ports
  assign rs1_addr = in_rs1;
  assign rs2_addr = in_rs2;

  // which sources this opcode really reads
  assign use_rs1 = core_pkg::reads_rs1(in_op);
  assign use_rs2 = core_pkg::reads_rs2(in_op);

  // RAW check against both in-flight destinations except x0
  assign ex_conflict = ex_valid && (ex_rd != '0) &&
                       ((use_rs1 && (in_rs1 == ex_rd)) ||
                        (use_rs2 && (in_rs2 == ex_rd)));

  assign wb_conflict = wb_valid && (wb_rd != '0) &&
                       ((use_rs1 && (in_rs1 == wb_rd)) ||
                        (use_rs2 && (in_rs2 == wb_rd)));

  // without bypass paths a writeback stage conflict stalls too
  assign busy = in_valid && (ex_conflict || wb_conflict);

  assign accept = in_valid && !busy;

  // operand select
  always_comb begin
    if (in_op == core_pkg::op_lui) begin
      operand_a = '0;
    end else begin
      operand_a = rs1_data;
    end

    if (in_op == core_pkg::op_reg) begin
      operand_b = rs2_data;
    end else begin
      operand_b = in_imm;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      exec.valid <= 1'b0;
    end else begin
      exec.valid <= accept;
    end
  end

  // payload only loads on acceptance
  always_ff @(posedge clock) begin
    if (accept) begin
      exec.op        <= in_op;
      exec.fn        <= in_fn;
      exec.rd        <= in_rd;
      exec.operand_a <= operand_a;
      exec.operand_b <= operand_b;
    end
  end

  // the source holds a stalled instruction until it is taken
  assert property (@(posedge clock) disable iff (reset)
    busy |=> in_valid && $stable({in_op, in_fn, in_rd, in_rs1, in_rs2, in_imm}));

endmodule

`default_nettype wire

// File: design/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
  input  logic                clock,
  input  logic                reset,
  input  core_pkg::reg_addr_t rs1_addr,
  input  core_pkg::reg_addr_t rs2_addr,
  input  logic                write_enable,
  input  core_pkg::reg_addr_t write_addr,
  input  core_pkg::data_t     write_data,
  output core_pkg::data_t     rs1_data,
  output core_pkg::data_t     rs2_data
);

  core_pkg::data_t regs [core_pkg::reg_count];

  // x0 is never written
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < core_pkg::reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (write_enable && (write_addr != '0)) begin
      regs[write_addr] <= write_data;
    end
  end

  // combinational reads without bypass
  always_comb begin
    if (rs1_addr == '0) begin
      rs1_data = '0;
    end else begin
      rs1_data = regs[rs1_addr];
    end

    if (rs2_addr == '0) begin
      rs2_data = '0;
    end else begin
      rs2_data = regs[rs2_addr];
    end
  end

  // writeback data from the pipe must be fully known
  assert property (@(posedge clock) disable iff (reset)
    write_enable |-> !$isunknown(write_data));

endmodule

`default_nettype wire

// File: list.f
design/core_pkg.sv
design/exec_if.sv
design/register_file.sv
design/issue_stage.sv
design/execute_pipe.sv
design/core_slice.sv
verification/core_slice_checker.sv
verification/core_slice_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f list.f --top-module core_slice_tb -o core_slice_sim
./obj_dir/core_slice_sim | tee sim.log
if grep -qx "Simulation finished: PASS" sim.log; then
  exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1

// File: verification/core_slice_checker.sv
`timescale 1ns/1ps
`default_nettype none

module core_slice_checker (
  input  logic                clock,
  input  logic                reset,
  input  logic                in_valid,
  input  core_pkg::opcode_e   in_op,
  input  core_pkg::alu_fn_e   in_fn,
  input  core_pkg::reg_addr_t in_rd,
  input  core_pkg::reg_addr_t in_rs1,
  input  core_pkg::reg_addr_t in_rs2,
  input  core_pkg::data_t     in_imm,
  input  logic                busy,
  input  logic                wb_valid,
  input  core_pkg::reg_addr_t wb_rd,
  input  core_pkg::data_t     wb_data,
  output logic                pending,
  output int                  busy_errors,
  output int                  wb_errors,
  output int                  writebacks
);

  // model register file and expected pipeline stages
  core_pkg::data_t     model_regs [core_pkg::reg_count];
  logic                ex_valid_exp;
  core_pkg::reg_addr_t ex_rd_exp;
  core_pkg::data_t     ex_data_exp;
  logic                wb_valid_exp;
  core_pkg::reg_addr_t wb_rd_exp;
  core_pkg::data_t     wb_data_exp;
  logic                busy_exp;

  assign pending = ex_valid_exp || wb_valid_exp;

  // offered instruction reads register rd
  function automatic logic reads_reg(core_pkg::reg_addr_t rd);
    return (rd != '0) &&
           (((in_op != core_pkg::op_lui) && (in_rs1 == rd)) ||
            ((in_op == core_pkg::op_reg) && (in_rs2 == rd)));
  endfunction

  function automatic core_pkg::data_t expected_result();
    core_pkg::data_t a;
    core_pkg::data_t b;
    a = model_regs[in_rs1];
    if (in_op == core_pkg::op_reg) begin
      b = model_regs[in_rs2];
    end else begin
      b = in_imm;
    end
    if (in_op == core_pkg::op_lui) begin
      return in_imm;
    end
    case (in_fn)
      core_pkg::alu_add: return a + b;
      core_pkg::alu_sub: return a - b;
      core_pkg::alu_xor: return a ^ b;
      default:           return a & b;
    endcase
  endfunction

  always @(posedge clock) begin
    if (reset) begin
      ex_valid_exp <= 1'b0;
      wb_valid_exp <= 1'b0;
      for (int i = 0; i < core_pkg::reg_count; i++) begin
        model_regs[i] <= '0;
      end
    end else begin
      busy_exp = in_valid && ((ex_valid_exp && reads_reg(ex_rd_exp)) ||
                              (wb_valid_exp && reads_reg(wb_rd_exp)));
      if (busy !== busy_exp) begin
        $display("error at %0d ns: busy expected %0b, actual %0b", $time, busy_exp, busy);
        busy_errors++;
      end
      if (wb_valid !== wb_valid_exp) begin
        $display("error at %0d ns: wb_valid expected %0b, actual %0b",
                 $time, wb_valid_exp, wb_valid);
        wb_errors++;
      end else if (wb_valid_exp) begin
        writebacks++;
        if (wb_rd !== wb_rd_exp) begin
          $display("error at %0d ns: wb_rd expected %0d, actual %0d", $time, wb_rd_exp, wb_rd);
          wb_errors++;
        end
        if (wb_data !== wb_data_exp) begin
          $display("error at %0d ns: wb_data expected 0x%h, actual 0x%h",
                   $time, wb_data_exp, wb_data);
          wb_errors++;
        end
      end
      // retire the writeback stage and shift both stages
      if (wb_valid_exp && (wb_rd_exp != '0)) begin
        model_regs[wb_rd_exp] <= wb_data_exp;
      end
      wb_valid_exp <= ex_valid_exp;
      wb_rd_exp    <= ex_rd_exp;
      wb_data_exp  <= ex_data_exp;
      ex_valid_exp <= in_valid && !busy_exp;
      if (in_valid && !busy_exp) begin
        ex_rd_exp   <= in_rd;
        ex_data_exp <= expected_result();
      end
    end
  end

endmodule

`default_nettype wire

// File: verification/core_slice_patterns.txt
# op fn rd rs1 rs2 imm gap : all hex except gap, the idle cycles after acceptance
# op 37 lui, 13 register-immediate, 33 register-register; fn 0 add, 1 sub, 2 xor, 3 and
37 3 1 0 0 12345000 3
37 0 2 0 0 0000f0f0 3
13 0 3 1 0 00000678 3
13 1 4 2 0 00000001 3
13 2 5 1 0 ffffffff 3
13 3 6 2 0 000000ff 3
33 0 7 1 2 00000000 3
33 1 8 2 1 00000000 3
33 2 9 1 2 00000000 3
33 3 a 1 3 00000000 3
# execute stage conflicts on rs1 and on rs2
37 0 b 0 0 00000a5a 0
13 0 c b 0 00000005 3
37 0 d 0 0 00000077 0
33 2 e 1 d 00000000 3
# writeback stage conflict behind an independent instruction
37 0 f 0 0 00001000 0
13 0 3 2 0 00000001 0
13 3 5 f 0 0000ffff 3
# no stall cases, x0 written then read
13 0 0 1 0 00000055 0
33 0 7 0 2 00000000 3
37 0 8 0 0 00000111 0
37 0 9 8 0 00000222 3
37 0 a 0 0 00000333 0
13 2 b 1 a 0000000f 3
# back to back, then a chain ending in a writeback conflict
13 0 c 1 0 00000001 0
13 1 d 2 0 00000002 0
13 2 e 3 0 00000003 0
13 3 f 4 0 0000ffff 0
33 0 1 c d 00000000 0
33 3 2 f e 00000000 4
33 0 5 0 0 00000000 4

// File: verification/core_slice_tb.sv
`timescale 1ns/1ps
`default_nettype none

module core_slice_tb;

  logic                clock;
  logic                reset;
  logic                in_valid;
  core_pkg::opcode_e   in_op;
  core_pkg::alu_fn_e   in_fn;
  core_pkg::reg_addr_t in_rd;
  core_pkg::reg_addr_t in_rs1;
  core_pkg::reg_addr_t in_rs2;
  core_pkg::data_t     in_imm;
  logic                busy;
  logic                wb_valid;
  core_pkg::reg_addr_t wb_rd;
  core_pkg::data_t     wb_data;
  logic                pending;
  int                  busy_errors;
  int                  wb_errors;
  int                  writebacks;
  int                  run_failures;

  core_slice dut0 (.*);

  core_slice_checker checker0 (.*);

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  // entered and left on a falling edge while the instruction is driven
  task automatic wait_accept(output logic taken);
    int waited;
    logic stalled;
    taken = 1'b0;
    waited = 0;
    while (!taken && (waited < 20)) begin
      #1;
      stalled = busy;
      @(negedge clock);
      if (stalled) begin
        waited++;
      end else begin
        taken = 1'b1;
      end
    end
  endtask

  task automatic play_patterns();
    int fd;
    int fields;
    int gap;
    int line_no;
    logic taken;
    string line;
    logic [31:0] field_val [6];
    fd = $fopen("verification/core_slice_patterns.txt", "r");
    if (fd == 0) begin
      $display("cannot open verification/core_slice_patterns.txt");
      run_failures++;
      return;
    end
    line_no = 0;
    while (!$feof(fd) && (run_failures == 0)) begin
      line_no++;
      if (($fgets(line, fd) != 0) && (line.getc(0) != "#")) begin
        fields = $sscanf(line, "%h %h %h %h %h %h %d", field_val[0], field_val[1],
                         field_val[2], field_val[3], field_val[4], field_val[5], gap);
        if (fields == 7) begin
          in_valid = 1'b1;
          in_op    = core_pkg::opcode_e'(field_val[0][6:0]);
          in_fn    = core_pkg::alu_fn_e'(field_val[1][1:0]);
          in_rd    = field_val[2][3:0];
          in_rs1   = field_val[3][3:0];
          in_rs2   = field_val[4][3:0];
          in_imm   = field_val[5];
          wait_accept(taken);
          in_valid = 1'b0;
          if (!taken) begin
            $display("pattern line %0d was never accepted, busy stayed high for 20 cycles",
                     line_no);
            run_failures++;
          end
          repeat (gap) @(negedge clock);
        end
      end
    end
    $fclose(fd);
  endtask

  // let the last two instructions write back
  task automatic drain_pipe();
    int waited;
    waited = 0;
    while (pending && (waited < 10)) begin
      @(negedge clock);
      waited++;
    end
    if (pending) begin
      $display("pipeline still held instructions after 10 drain cycles");
      run_failures++;
    end
  endtask

  initial begin
    reset        = 1'b1;
    in_valid     = 1'b0;
    in_op        = core_pkg::op_lui;
    in_fn        = core_pkg::alu_add;
    in_rd        = '0;
    in_rs1       = '0;
    in_rs2       = '0;
    in_imm       = '0;
    run_failures = 0;
    repeat (2) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    play_patterns();
    drain_pipe();
    $display("error counts: busy %0d, writeback %0d, run failures %0d (%0d writebacks seen)",
             busy_errors, wb_errors, run_failures, writebacks);
    if ((busy_errors == 0) && (wb_errors == 0) && (run_failures == 0) && (writebacks > 0)) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
